/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_control.sv
  - src/rv_imm_gen.sv
  - src/rv_regfile.sv
  - src/rv_alu.sv
  - src/rv_next_pc.sv
  - src/rv_lsu.sv
  - src/rv_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_rv_core.sv

/* rv_core.f */
+incdir+include
src/rv_pkg.sv
src/rv_control.sv
src/rv_imm_gen.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_next_pc.sv
src/rv_lsu.sv
src/rv_core.sv
tb/tb_rv_core.sv

/* src/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::alu_add: begin
        result = a + b;
      end
      rv_pkg::alu_sub: begin
        result = a - b;
      end
      rv_pkg::alu_sll: begin
        result = a << shamt;
      end
      rv_pkg::alu_slt: begin
        result = {{(rv_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
      end
      rv_pkg::alu_sltu: begin
        result = {{(rv_pkg::xlen-1){1'b0}}, a < b};
      end
      rv_pkg::alu_xor: begin
        result = a ^ b;
      end
      rv_pkg::alu_srl: begin
        result = a >> shamt;
      end
      rv_pkg::alu_sra: begin
        result = rv_pkg::word_t'($signed(a) >>> shamt);
      end
      rv_pkg::alu_or: begin
        result = a | b;
      end
      rv_pkg::alu_and: begin
        result = a & b;
      end
      // lui
      rv_pkg::alu_pass_b: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* src/rv_control.sv */
`timescale 1ns/1ps

module rv_control (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::rv_insn_u insn,
  output rv_pkg::ctrl_t    ctrl,
  output logic             halt,
  output logic             illegal
);

  rv_pkg::ctrl_t dec;
  logic          is_ecall;
  logic          bad;
  logic          alt;

  assign alt = (insn.r.funct7 == rv_pkg::funct7_alt);

  always_comb begin
    dec         = '0;
    dec.alu_op  = rv_pkg::alu_add;
    dec.imm_fmt = rv_pkg::fmt_i;
    dec.wb_sel  = rv_pkg::wb_alu;
    dec.mem_f3  = insn.r.funct3;
    is_ecall    = 1'b0;
    bad         = 1'b0;
    case (insn.r.opcode)
      rv_pkg::op_lui: begin
        dec.reg_we   = 1'b1;
        dec.alu_op   = rv_pkg::alu_pass_b;
        dec.b_is_imm = 1'b1;
        dec.imm_fmt  = rv_pkg::fmt_u;
      end
      rv_pkg::op_auipc: begin
        dec.reg_we   = 1'b1;
        dec.a_is_pc  = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.imm_fmt  = rv_pkg::fmt_u;
      end
      rv_pkg::op_jal: begin
        dec.reg_we  = 1'b1;
        dec.wb_sel  = rv_pkg::wb_pc4;
        dec.is_jal  = 1'b1;
        dec.imm_fmt = rv_pkg::fmt_j;
      end
      rv_pkg::op_jalr: begin
        // target comes from the alu sum rs1 + imm
        dec.reg_we   = 1'b1;
        dec.wb_sel   = rv_pkg::wb_pc4;
        dec.is_jalr  = 1'b1;
        dec.b_is_imm = 1'b1;
        bad          = (insn.r.funct3 != 3'b000);
      end
      rv_pkg::op_branch: begin
        dec.is_branch = 1'b1;
        dec.imm_fmt   = rv_pkg::fmt_b;
        // funct3 010 and 011 are unused
        bad           = (insn.r.funct3[2:1] == 2'b01);
      end
      rv_pkg::op_load: begin
        dec.reg_we   = 1'b1;
        dec.wb_sel   = rv_pkg::wb_load;
        dec.is_load  = 1'b1;
        dec.b_is_imm = 1'b1;
        bad = !(insn.r.funct3 inside {rv_pkg::f3_byte, rv_pkg::f3_half, rv_pkg::f3_word,
                                      rv_pkg::f3_byte_u, rv_pkg::f3_half_u});
      end
      rv_pkg::op_store: begin
        dec.is_store = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.imm_fmt  = rv_pkg::fmt_s;
        bad = !(insn.r.funct3 inside {rv_pkg::f3_byte, rv_pkg::f3_half, rv_pkg::f3_word});
      end
      rv_pkg::op_imm: begin
        dec.reg_we   = 1'b1;
        dec.b_is_imm = 1'b1;
        // upper imm bits are an opcode bit only for right shifts
        dec.alu_op   = {alt && (insn.r.funct3 == 3'b101), insn.r.funct3};
        if (insn.r.funct3 == 3'b001) begin
          bad = (insn.r.funct7 != 7'd0);
        end else if (insn.r.funct3 == 3'b101) begin
          bad = (insn.r.funct7 != 7'd0) && !alt;
        end
      end
      rv_pkg::op_reg: begin
        dec.reg_we = 1'b1;
        dec.alu_op = {alt, insn.r.funct3};
        bad = (insn.r.funct7 != 7'd0) && !(alt && (insn.r.funct3 inside {3'b000, 3'b101}));
      end
      rv_pkg::op_system: begin
        // only ecall, all of bits 31:7 zero
        is_ecall = (insn.u.imm_31_12 == '0) && (insn.u.rd == '0);
        bad      = !is_ecall;
      end
      default: begin
        bad = 1'b1;
      end
    endcase
  end

  always_comb begin
    ctrl          = dec;
    ctrl.reg_we   = dec.reg_we & ~bad & ~rst;
    ctrl.is_store = dec.is_store & ~bad & ~rst;
  end

  assign halt    = is_ecall & ~rst;
  assign illegal = bad;

  a_load_store_excl: assert property (@(posedge clk) disable iff (rst)
    !(ctrl.is_load && ctrl.is_store));

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output rv_pkg::strb_t dmem_we,
  input  rv_pkg::word_t dmem_rdata,
  output logic          halt
);

  rv_pkg::rv_insn_u insn;
  rv_pkg::ctrl_t    ctrl;
  logic             illegal;
  rv_pkg::word_t    imm;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_a;
  rv_pkg::word_t    alu_b;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    pc;
  rv_pkg::word_t    pc_plus4;
  rv_pkg::word_t    load_data;
  rv_pkg::word_t    rd_data;

  assign insn      = imem_data;
  assign imem_addr = pc;

  rv_control u_control (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .ctrl    (ctrl),
    .halt    (halt),
    .illegal (illegal)
  );

  rv_imm_gen u_imm_gen (
    .insn (insn),
    .fmt  (ctrl.imm_fmt),
    .imm  (imm)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (ctrl.reg_we),
    .rd       (insn.r.rd),
    .rd_data  (rd_data),
    .rs1      (insn.r.rs1),
    .rs2      (insn.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // auipc takes the pc, immediates replace rs2
  assign alu_a = ctrl.a_is_pc ? pc : rs1_data;
  assign alu_b = ctrl.b_is_imm ? imm : rs2_data;

  rv_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_next_pc u_next_pc (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .alu_sum  (alu_result),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  rv_lsu u_lsu (
    .ctrl       (ctrl),
    .addr       (alu_result),
    .rs2_data   (rs2_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data)
  );

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::wb_load: rd_data = load_data;
      rv_pkg::wb_pc4:  rd_data = pc_plus4;
      default:         rd_data = alu_result;
    endcase
  end

  a_no_illegal: assert property (@(posedge clk) disable iff (rst) !illegal);

endmodule

/* src/rv_imm_gen.sv */
`timescale 1ns/1ps

module rv_imm_gen (
  input  rv_pkg::rv_insn_u insn,
  input  rv_pkg::imm_fmt_t fmt,
  output rv_pkg::word_t    imm
);

  always_comb begin
    case (fmt)
      rv_pkg::fmt_i: begin
        imm = {{20{insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
      end
      rv_pkg::fmt_s: begin
        imm = {{20{insn.s.imm_11_5[6]}}, insn.s.imm_11_5, insn.s.imm_4_0};
      end
      rv_pkg::fmt_b: begin
        imm = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
               insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
      end
      rv_pkg::fmt_u: begin
        imm = {insn.u.imm_31_12, 12'b0};
      end
      rv_pkg::fmt_j: begin
        imm = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
               insn.j.imm_11, insn.j.imm_10_1, 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

/* src/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t addr,
  input  rv_pkg::word_t rs2_data,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output rv_pkg::strb_t dmem_we,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::word_t load_data
);

  logic mem_active;

  assign mem_active = ctrl.is_load | ctrl.is_store;
  assign dmem_addr  = mem_active ? addr : '0;

  // sub-word stores go to the low lanes of the word
  always_comb begin
    dmem_we    = 4'b0000;
    dmem_wdata = '0;
    if (ctrl.is_store) begin
      case (ctrl.mem_f3)
        rv_pkg::f3_byte: begin
          dmem_we    = 4'b0001;
          dmem_wdata = {24'b0, rs2_data[7:0]};
        end
        rv_pkg::f3_half: begin
          dmem_we    = 4'b0011;
          dmem_wdata = {16'b0, rs2_data[15:0]};
        end
        rv_pkg::f3_word: begin
          dmem_we    = 4'b1111;
          dmem_wdata = rs2_data;
        end
        default: begin
          dmem_we = 4'b0000;
        end
      endcase
    end
  end

  always_comb begin
    case (ctrl.mem_f3)
      rv_pkg::f3_byte:   load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
      rv_pkg::f3_half:   load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
      rv_pkg::f3_byte_u: load_data = {24'b0, dmem_rdata[7:0]};
      rv_pkg::f3_half_u: load_data = {16'b0, dmem_rdata[15:0]};
      rv_pkg::f3_word:   load_data = dmem_rdata;
      default:           load_data = dmem_rdata;
    endcase
  end

  // word-aligned only, lanes never rotate
  always_comb begin
    if (mem_active) begin
      a_addr_aligned: assert final (addr[1:0] == 2'b00);
    end
  end

endmodule

/* src/rv_next_pc.sv */
`timescale 1ns/1ps

module rv_next_pc (
  input  logic           clk,
  input  logic           rst,
  input  rv_pkg::ctrl_t  ctrl,
  input  rv_pkg::word_t  rs1_data,
  input  rv_pkg::word_t  rs2_data,
  input  rv_pkg::word_t  imm,
  input  rv_pkg::word_t  alu_sum,
  output rv_pkg::word_t  pc,
  output rv_pkg::word_t  pc_plus4
);

  rv_pkg::word_t pc_q;
  rv_pkg::word_t pc_next;
  logic          taken;

  // branch condition from funct3
  always_comb begin
    case (ctrl.mem_f3)
      rv_pkg::f3_beq:  taken = (rs1_data == rs2_data);
      rv_pkg::f3_bne:  taken = (rs1_data != rs2_data);
      rv_pkg::f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::f3_bltu: taken = (rs1_data < rs2_data);
      rv_pkg::f3_bgeu: taken = (rs1_data >= rs2_data);
      default:         taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc_q + 32'd4;

  always_comb begin
    if (ctrl.is_jalr) begin
      pc_next = {alu_sum[rv_pkg::xlen-1:1], 1'b0};
    end else if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
      pc_next = pc_q + imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc = pc_q;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00);

endmodule

/* src/rv_pkg.sv */
package rv_pkg;

  localparam int xlen     = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      strb_t;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // marks SUB and SRA/SRAI
  localparam logic [6:0] funct7_alt = 7'b0100000;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // low three bits follow funct3, bit 3 is the funct7 alternate bit
  typedef logic [3:0] alu_op_t;
  localparam alu_op_t alu_add    = 4'b0000;
  localparam alu_op_t alu_sll    = 4'b0001;
  localparam alu_op_t alu_slt    = 4'b0010;
  localparam alu_op_t alu_sltu   = 4'b0011;
  localparam alu_op_t alu_xor    = 4'b0100;
  localparam alu_op_t alu_srl    = 4'b0101;
  localparam alu_op_t alu_or     = 4'b0110;
  localparam alu_op_t alu_and    = 4'b0111;
  localparam alu_op_t alu_sub    = 4'b1000;
  localparam alu_op_t alu_sra    = 4'b1101;
  localparam alu_op_t alu_pass_b = 4'b1111;

  typedef logic [1:0] wb_sel_t;
  localparam wb_sel_t wb_alu  = 2'd0;
  localparam wb_sel_t wb_load = 2'd1;
  localparam wb_sel_t wb_pc4  = 2'd2;

  typedef logic [2:0] imm_fmt_t;
  localparam imm_fmt_t fmt_i = 3'd0;
  localparam imm_fmt_t fmt_s = 3'd1;
  localparam imm_fmt_t fmt_b = 3'd2;
  localparam imm_fmt_t fmt_u = 3'd3;
  localparam imm_fmt_t fmt_j = 3'd4;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } insn_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } insn_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } insn_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } insn_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } insn_j_t;

  // one fetched word, seen through each encoding format
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_s_t s;
    insn_b_t b;
    insn_u_t u;
    insn_j_t j;
  } rv_insn_u;

  typedef struct packed {
    logic       reg_we;
    alu_op_t    alu_op;
    logic       a_is_pc;
    logic       b_is_imm;
    imm_fmt_t   imm_fmt;
    wb_sel_t    wb_sel;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_load;
    logic       is_store;
    logic [2:0] mem_f3;
  } ctrl_t;

endpackage

/* src/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  rv_pkg::word_t regs [rv_pkg::num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // reads see the value before this cycle's write
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

/* include/rv_tb_program.svh */
`ifndef RV_TB_PROGRAM_SVH
`define RV_TB_PROGRAM_SVH

// base opcodes from the rv32i spec
localparam logic [6:0] opc_lui    = 7'b0110111;
localparam logic [6:0] opc_auipc  = 7'b0010111;
localparam logic [6:0] opc_jalr   = 7'b1100111;
localparam logic [6:0] opc_load   = 7'b0000011;
localparam logic [6:0] opc_imm    = 7'b0010011;
localparam logic [6:0] opc_system = 7'b1110011;

// x1 points here, the poison word sits at the top of data memory
localparam int data_base  = 'h100;
localparam int poison_off = 252;

typedef struct packed {
  logic [31:0] addr;
  logic [3:0]  strb;
  logic [31:0] data;
} store_t;

logic [31:0] program_q [$];
store_t      expected_q [$];
string       store_name_q [$];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input int rd, input int rs1, input int rs2);
  return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                      input int rd, input int rs1, input int imm);
  return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_s(input logic [2:0] f3, input int rs2, input int rs1,
                                      input int imm);
  logic [11:0] im;
  im = 12'(imm);
  return {im[11:5], 5'(rs2), 5'(rs1), f3, im[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                      input int imm);
  logic [12:0] im;
  im = 13'(imm);
  return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int imm20);
  return {20'(imm20), 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_j(input int rd, input int imm);
  logic [20:0] im;
  im = 21'(imm);
  return {im[20], im[10:1], im[11], im[19:12], 5'(rd), 7'b1101111};
endfunction

// initial data memory contents, never repeats across addresses
function automatic logic [31:0] dmem_fill_word(input logic [31:0] addr);
  return 32'hc0de_0000 ^ addr;
endfunction

function automatic void emit(input logic [31:0] insn);
  program_q.push_back(insn);
endfunction

function automatic void emit_poison();
  emit(enc_s(3'b010, 0, 1, poison_off));
endfunction

function automatic void load_program();
  program_q.delete();
  // x1 data base, x2 = -20, x3 = 7
  emit(enc_i(opc_imm, 3'b000, 1, 0, data_base));
  emit(enc_i(opc_imm, 3'b000, 2, 0, -20));
  emit(enc_i(opc_imm, 3'b000, 3, 0, 7));
  // addi slti sltiu xori ori andi slli srli srai
  emit(enc_i(opc_imm, 3'b000, 4, 2, 100));
  emit(enc_s(3'b010, 4, 1, 0));
  emit(enc_i(opc_imm, 3'b010, 4, 2, -5));
  emit(enc_s(3'b010, 4, 1, 4));
  emit(enc_i(opc_imm, 3'b011, 4, 2, 5));
  emit(enc_s(3'b010, 4, 1, 8));
  emit(enc_i(opc_imm, 3'b100, 4, 2, 'h0f0));
  emit(enc_s(3'b010, 4, 1, 12));
  emit(enc_i(opc_imm, 3'b110, 4, 3, 'h100));
  emit(enc_s(3'b010, 4, 1, 16));
  emit(enc_i(opc_imm, 3'b111, 4, 2, 'h0ff));
  emit(enc_s(3'b010, 4, 1, 20));
  emit(enc_i(opc_imm, 3'b001, 4, 3, 4));
  emit(enc_s(3'b010, 4, 1, 24));
  emit(enc_i(opc_imm, 3'b101, 4, 2, 4));
  emit(enc_s(3'b010, 4, 1, 28));
  // srai, funct7 0100000 rides in the upper immediate bits
  emit(enc_i(opc_imm, 3'b101, 4, 2, 'h402));
  emit(enc_s(3'b010, 4, 1, 32));
  // add sub sll slt sltu xor srl sra or and
  emit(enc_r(7'h00, 3'b000, 4, 2, 3));
  emit(enc_s(3'b010, 4, 1, 36));
  emit(enc_r(7'h20, 3'b000, 4, 2, 3));
  emit(enc_s(3'b010, 4, 1, 40));
  emit(enc_r(7'h00, 3'b001, 4, 3, 3));
  emit(enc_s(3'b010, 4, 1, 44));
  emit(enc_r(7'h00, 3'b010, 4, 2, 3));
  emit(enc_s(3'b010, 4, 1, 48));
  emit(enc_r(7'h00, 3'b011, 4, 2, 3));
  emit(enc_s(3'b010, 4, 1, 52));
  emit(enc_r(7'h00, 3'b100, 4, 2, 3));
  emit(enc_s(3'b010, 4, 1, 56));
  emit(enc_r(7'h00, 3'b101, 4, 2, 3));
  emit(enc_s(3'b010, 4, 1, 60));
  emit(enc_r(7'h20, 3'b101, 4, 2, 3));
  emit(enc_s(3'b010, 4, 1, 64));
  emit(enc_r(7'h00, 3'b110, 4, 2, 3));
  emit(enc_s(3'b010, 4, 1, 68));
  emit(enc_r(7'h00, 3'b111, 4, 2, 3));
  emit(enc_s(3'b010, 4, 1, 72));
  // lui, then auipc at 0xac, then a write to x0
  emit(enc_u(opc_lui, 4, 'h12345));
  emit(enc_s(3'b010, 4, 1, 76));
  emit(enc_u(opc_auipc, 4, 1));
  emit(enc_s(3'b010, 4, 1, 80));
  emit(enc_i(opc_imm, 3'b000, 0, 0, 5));
  emit(enc_s(3'b010, 0, 1, 84));
  // 0x1234f0a5 has bits 7 and 15 set
  emit(enc_u(opc_lui, 5, 'h1234f));
  emit(enc_i(opc_imm, 3'b000, 5, 5, 'h0a5));
  emit(enc_s(3'b010, 5, 1, 88));
  emit(enc_i(opc_load, 3'b000, 6, 1, 88));
  emit(enc_s(3'b010, 6, 1, 92));
  emit(enc_i(opc_load, 3'b001, 6, 1, 88));
  emit(enc_s(3'b010, 6, 1, 96));
  emit(enc_i(opc_load, 3'b100, 6, 1, 88));
  emit(enc_s(3'b010, 6, 1, 100));
  emit(enc_i(opc_load, 3'b101, 6, 1, 88));
  emit(enc_s(3'b010, 6, 1, 104));
  // sb and sh over fill words, then read the whole words back
  emit(enc_s(3'b000, 2, 1, 108));
  emit(enc_s(3'b001, 2, 1, 112));
  emit(enc_i(opc_load, 3'b010, 6, 1, 108));
  emit(enc_s(3'b010, 6, 1, 116));
  emit(enc_i(opc_load, 3'b010, 6, 1, 112));
  emit(enc_s(3'b010, 6, 1, 120));
  // per branch type a not-taken then a taken one, a wrong turn hits the poison store
  emit(enc_b(3'b000, 2, 3, 8));
  emit(enc_b(3'b000, 3, 3, 8));
  emit_poison();
  emit(enc_b(3'b001, 3, 3, 8));
  emit(enc_b(3'b001, 2, 3, 8));
  emit_poison();
  emit(enc_b(3'b100, 3, 2, 8));
  emit(enc_b(3'b100, 2, 3, 8));
  emit_poison();
  emit(enc_b(3'b101, 2, 3, 8));
  emit(enc_b(3'b101, 3, 2, 8));
  emit_poison();
  emit(enc_b(3'b110, 2, 3, 8));
  emit(enc_b(3'b110, 3, 2, 8));
  emit_poison();
  emit(enc_b(3'b111, 3, 2, 8));
  emit(enc_b(3'b111, 2, 3, 8));
  emit_poison();
  // jal at 0x148, auipc at 0x154, jalr with an odd offset
  emit(enc_j(7, 8));
  emit_poison();
  emit(enc_s(3'b010, 7, 1, 124));
  emit(enc_u(opc_auipc, 8, 0));
  emit(enc_i(opc_jalr, 3'b000, 9, 8, 13));
  emit_poison();
  emit(enc_s(3'b010, 9, 1, 128));
  emit(enc_i(opc_system, 3'b000, 0, 0, 0));
endfunction

function automatic void expect_store(input string name, input int off, input logic [3:0] strb,
                                     input logic [31:0] data);
  store_t s;
  s.addr = 32'(data_base + off);
  s.strb = strb;
  s.data = data;
  expected_q.push_back(s);
  store_name_q.push_back(name);
endfunction

function automatic void load_expected();
  expected_q.delete();
  store_name_q.delete();
  expect_store("addi", 0, 4'b1111, 32'h0000_0050);
  expect_store("slti", 4, 4'b1111, 32'h0000_0001);
  expect_store("sltiu", 8, 4'b1111, 32'h0000_0000);
  expect_store("xori", 12, 4'b1111, 32'hffff_ff1c);
  expect_store("ori", 16, 4'b1111, 32'h0000_0107);
  expect_store("andi", 20, 4'b1111, 32'h0000_00ec);
  expect_store("slli", 24, 4'b1111, 32'h0000_0070);
  expect_store("srli", 28, 4'b1111, 32'h0fff_fffe);
  expect_store("srai", 32, 4'b1111, 32'hffff_fffb);
  expect_store("add", 36, 4'b1111, 32'hffff_fff3);
  expect_store("sub", 40, 4'b1111, 32'hffff_ffe5);
  expect_store("sll", 44, 4'b1111, 32'h0000_0380);
  expect_store("slt", 48, 4'b1111, 32'h0000_0001);
  expect_store("sltu", 52, 4'b1111, 32'h0000_0000);
  expect_store("xor", 56, 4'b1111, 32'hffff_ffeb);
  expect_store("srl", 60, 4'b1111, 32'h01ff_ffff);
  expect_store("sra", 64, 4'b1111, 32'hffff_ffff);
  expect_store("or", 68, 4'b1111, 32'hffff_ffef);
  expect_store("and", 72, 4'b1111, 32'h0000_0004);
  expect_store("lui", 76, 4'b1111, 32'h1234_5000);
  expect_store("auipc", 80, 4'b1111, 32'h0000_10ac);
  expect_store("x0 write", 84, 4'b1111, 32'h0000_0000);
  expect_store("sw word", 88, 4'b1111, 32'h1234_f0a5);
  expect_store("lb", 92, 4'b1111, 32'hffff_ffa5);
  expect_store("lh", 96, 4'b1111, 32'hffff_f0a5);
  expect_store("lbu", 100, 4'b1111, 32'h0000_00a5);
  expect_store("lhu", 104, 4'b1111, 32'h0000_f0a5);
  expect_store("sb", 108, 4'b0001, 32'h0000_00ec);
  expect_store("sh", 112, 4'b0011, 32'h0000_ffec);
  expect_store("lw after sb", 116, 4'b1111,
               (dmem_fill_word(32'h16c) & 32'hffff_ff00) | 32'h0000_00ec);
  expect_store("lw after sh", 120, 4'b1111,
               (dmem_fill_word(32'h170) & 32'hffff_0000) | 32'h0000_ffec);
  expect_store("jal link", 124, 4'b1111, 32'h0000_014c);
  expect_store("jalr link", 128, 4'b1111, 32'h0000_015c);
endfunction

`endif

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  `include "rv_tb_program.svh"

  localparam int          clk_period   = 100;
  localparam int          reset_cycles = 2;
  localparam int          halt_timeout = 200;
  localparam int          mem_words    = 128;
  localparam logic [31:0] poison_addr  = 32'(data_base + poison_off);

  logic          clk;
  logic          rst;
  rv_pkg::word_t imem_addr;
  rv_pkg::word_t imem_data;
  rv_pkg::word_t dmem_addr;
  rv_pkg::word_t dmem_wdata;
  rv_pkg::strb_t dmem_we;
  rv_pkg::word_t dmem_rdata;
  logic          halt;

  logic [31:0] imem [mem_words];
  logic [31:0] dmem [mem_words];
  int          seen_count [];
  int          error_count;
  int          store_count;

  rv_core u_rv_core (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  always #(clk_period / 2) clk = ~clk;

  // both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[8:2]];
  assign dmem_rdata = dmem[dmem_addr[8:2]];

  always @(posedge clk) begin : dmem_write
    for (int b = 0; b < 4; b++) begin
      if (dmem_we[b]) begin
        dmem[dmem_addr[8:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

  function automatic int find_store(input logic [31:0] addr);
    int idx;
    idx = -1;
    foreach (expected_q[k]) begin
      if (expected_q[k].addr == addr) begin
        idx = k;
      end
    end
    return idx;
  endfunction

  function automatic bit store_matches(input logic [31:0] addr, input logic [3:0] strb,
                                       input logic [31:0] data);
    int idx;
    idx = find_store(addr);
    if (idx < 0) begin
      return 1'b0;
    end
    return (expected_q[idx].strb == strb) && (expected_q[idx].data == data);
  endfunction

  task automatic report_bad_store(input logic [31:0] addr, input logic [3:0] strb,
                                  input logic [31:0] data);
    int idx;
    idx = find_store(addr);
    if (idx < 0) begin
      $display("unexpected store of 0x%h to address 0x%h", data, addr);
    end else begin
      $display("FAIL %s: expected 0x%h strobe %b, actual 0x%h strobe %b",
               store_name_q[idx], expected_q[idx].data, expected_q[idx].strb, data, strb);
    end
    error_count++;
  endtask

  // the store being committed at this edge
  always @(posedge clk) begin : count_stores
    int idx;
    if (!rst && (dmem_we != 4'b0000)) begin
      store_count++;
      idx = find_store(dmem_addr);
      if (idx >= 0) begin
        seen_count[idx]++;
      end
    end
  end

  a_store_value: assert property (@(posedge clk) disable iff (rst)
    ((dmem_we != 4'b0000) && (dmem_addr != poison_addr))
      |-> store_matches(dmem_addr, dmem_we, dmem_wdata))
    else report_bad_store($sampled(dmem_addr), $sampled(dmem_we), $sampled(dmem_wdata));

  a_no_poison: assert property (@(posedge clk) disable iff (rst)
    !((dmem_we != 4'b0000) && (dmem_addr == poison_addr)))
    else begin
      $display("store to the poison address, a branch or jump went the wrong way");
      error_count++;
    end

  // fetches stay word-aligned inside instruction memory
  a_fetch_addr: assert property (@(posedge clk) disable iff (rst)
    (imem_addr[1:0] == 2'b00) && (imem_addr < 32'(mem_words * 4)))
    else begin
      $display("fetch from address 0x%h is misaligned or outside instruction memory",
               $sampled(imem_addr));
      error_count++;
    end

  initial begin
    int cycles;
    clk         = 1'b0;
    rst         = 1'b1;
    error_count = 0;
    store_count = 0;
    load_program();
    load_expected();
    seen_count = new[expected_q.size()];
    for (int k = 0; k < mem_words; k++) begin
      imem[k] = {16'hdead, 16'(k * 4)};
      dmem[k] = dmem_fill_word(32'(k * 4));
    end
    foreach (program_q[k]) begin
      imem[k] = program_q[k];
    end

    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;

    cycles = 0;
    while (!halt && (cycles < halt_timeout)) begin
      @(negedge clk);
      cycles++;
    end

    a_halt_seen: assert (halt) else begin
      $display("halt did not rise within %0d cycles", halt_timeout);
      error_count++;
    end
    foreach (seen_count[k]) begin
      a_store_once: assert (seen_count[k] == 1) else begin
        $display("FAIL %s: expected 1 store, actual %0d", store_name_q[k], seen_count[k]);
        error_count++;
      end
    end

    $display("stores seen: %0d, errors: %0d", store_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
